// ==== source/intExec_params.svh ====
`ifndef INTEXEC_PARAMS_SVH
`define INTEXEC_PARAMS_SVH

`default_nettype none

// Data and address width
`define XLEN 32
`define SQN_W 6
`define TAG_W 6
// Architectural register name
`define NM_W 5
`define BID_W 6

`default_nettype wire

`endif

// ==== source/intExecPkg.sv ====
`include "intExec_params.svh"

`default_nettype none

package intExecPkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`SQN_W-1:0] sqN_t;
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`NM_W-1:0] regNm_t;
    typedef logic [`BID_W-1:0] branchId_t;

    typedef enum logic [5:0] {
        INT_UNDEFINED,
        INT_ADD, INT_SUB, INT_XOR, INT_OR, INT_AND,
        INT_SLL, INT_SRL, INT_SRA, INT_SLT, INT_SLTU,
        INT_LUI, INT_AUIPC, INT_JAL, INT_JALR, INT_SYS,
        INT_BEQ, INT_BNE, INT_BLT, INT_BGE, INT_BLTU, INT_BGEU,
        INT_SH1ADD, INT_SH2ADD, INT_SH3ADD,
        INT_ANDN, INT_ORN, INT_XNOR,
        INT_SE_B, INT_SE_H, INT_ZE_H,
        INT_CLZ, INT_CTZ, INT_CPOP,
        INT_MIN, INT_MAX, INT_MINU, INT_MAXU,
        INT_ORC_B, INT_REV8
    } intOp_e;

    typedef enum logic [1:0] {
        FLAGS_NONE,
        FLAGS_EXCEPT,
        FLAGS_TRAP,
        FLAGS_BRK
    } flags_e;

    typedef struct packed {
        logic valid;
        intOp_e opcode;
        word_t srcA;
        word_t srcB;
        word_t imm;
        word_t pc;
        logic compressed;
        logic branchPred;
        branchId_t branchId;
        sqN_t sqN;
        sqN_t loadSqN;
        sqN_t storeSqN;
        tag_t tagDst;
        regNm_t nmDst;
    } exUop_s;

    typedef struct packed {
        logic valid;
        word_t result;
        tag_t tagDst;
        regNm_t nmDst;
        sqN_t sqN;
        flags_e flags;
        word_t pc;
        logic isBranch;
        logic branchTaken;
        branchId_t branchId;
    } resUop_s;

    typedef struct packed {
        logic isBranch;
        logic taken;
        logic mispred;
        word_t source;
        word_t address;
        logic isJump;
        branchId_t branchId;
        sqN_t sqN;
        sqN_t loadSqN;
        sqN_t storeSqN;
        logic compressed;
    } branchRes_s;

    // Sequence numbers wrap, so age comes from the signed difference
    function automatic logic isKilled(
        input logic invalidate,
        input sqN_t sqN,
        input sqN_t flushSqN
    );
        sqN_t diff;
        diff = sqN - flushSqN;
        return invalidate && ($signed(diff) > 0);
    endfunction

endpackage

`default_nettype wire

// ==== source/execUopIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface execUopIf;

    intExecPkg::exUop_s uop;
    intExecPkg::resUop_s resUop;
    intExecPkg::branchRes_s branch;

    modport source (
        output uop,
        output resUop,
        output branch
    );

    modport sink (
        input uop,
        input resUop,
        input branch
    );

endinterface

`default_nettype wire

// ==== source/bitCountUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitCountUnit (
    input wire intExecPkg::word_t value,
    output logic [5:0] leadZeros,
    output logic [5:0] popCount
);

    logic [1:0] sum1 [16];
    logic [2:0] sum2 [8];
    logic [3:0] sum3 [4];
    logic [4:0] sum4 [2];

    // Highest set bit wins and an all-zero word gives 32
    always_comb begin
        leadZeros = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (value[i]) begin
                leadZeros = 6'(31 - i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sum1[i] = {1'b0, value[2*i]} + {1'b0, value[2*i+1]};
        end
        for (int i = 0; i < 8; i++) begin
            sum2[i] = {1'b0, sum1[2*i]} + {1'b0, sum1[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            sum3[i] = {1'b0, sum2[2*i]} + {1'b0, sum2[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            sum4[i] = {1'b0, sum3[2*i]} + {1'b0, sum3[2*i+1]};
        end
        popCount = {1'b0, sum4[0]} + {1'b0, sum4[1]};
    end

endmodule

`default_nettype wire

// ==== source/issueStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueStage (
    input wire clk,
    input wire rst,
    input wire intExecPkg::exUop_s uopIn,
    input wire wbStall,
    input wire invalidate,
    input wire intExecPkg::sqN_t invalidateSqN,
    execUopIf.source out
);

    intExecPkg::exUop_s entry;
    logic killIn;
    logic killEntry;

    assign killIn = intExecPkg::isKilled(invalidate, uopIn.sqN, invalidateSqN);
    assign killEntry = intExecPkg::isKilled(invalidate, entry.sqN, invalidateSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            entry.valid <= 1'b0;
        end else if (!wbStall) begin
            entry <= uopIn;
            // A flush in the same cycle also catches the incoming op
            entry.valid <= uopIn.valid && !killIn;
        end else if (killEntry) begin
            entry.valid <= 1'b0;
        end
    end

    assign out.uop = entry;

endmodule

`default_nettype wire

// ==== source/intAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input wire clk,
    input wire rst,
    execUopIf.sink in,
    input wire wbStall,
    input wire invalidate,
    input wire intExecPkg::sqN_t invalidateSqN,
    execUopIf.source out,
    output wire fwdValid,
    output wire intExecPkg::tag_t fwdTag,
    output wire intExecPkg::word_t fwdResult
);

    intExecPkg::exUop_s uop;
    intExecPkg::word_t srcA;
    intExecPkg::word_t srcB;
    intExecPkg::word_t imm;
    intExecPkg::word_t srcARev;
    intExecPkg::word_t pcPlus2;
    intExecPkg::word_t pcPlus4;
    intExecPkg::word_t fallThrough;
    intExecPkg::word_t branchTarget;
    intExecPkg::word_t result;
    intExecPkg::flags_e flags;
    intExecPkg::resUop_s resNext;
    intExecPkg::branchRes_s branchNext;
    logic [5:0] leadZeros;
    logic [5:0] popCount;
    logic lessThan;
    logic lessThanU;
    logic isBranch;
    logic taken;
    logic killed;
    logic accept;

    assign uop = in.uop;
    assign srcA = uop.srcA;
    assign srcB = uop.srcB;
    assign imm = uop.imm;

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            srcARev[i] = srcA[31-i];
        end
    end

    // CTZ reuses the leading-zero search on the reversed word
    bitCountUnit bitCount_i (
        .value(uop.opcode == intExecPkg::INT_CTZ ? srcARev : srcA),
        .leadZeros(leadZeros),
        .popCount(popCount)
    );

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;
    assign pcPlus2 = uop.pc + 32'd2;
    assign pcPlus4 = uop.pc + 32'd4;
    assign fallThrough = uop.compressed ? pcPlus2 : pcPlus4;
    assign branchTarget = uop.pc + {{19{imm[12]}}, imm[12:0]};

    always_comb begin
        case (uop.opcode)
            intExecPkg::INT_ADD: result = srcA + srcB;
            intExecPkg::INT_SUB: result = srcA - srcB;
            intExecPkg::INT_XOR: result = srcA ^ srcB;
            intExecPkg::INT_OR: result = srcA | srcB;
            intExecPkg::INT_AND: result = srcA & srcB;
            intExecPkg::INT_SLL: result = srcA << srcB[4:0];
            intExecPkg::INT_SRL: result = srcA >> srcB[4:0];
            intExecPkg::INT_SRA: result = $signed(srcA) >>> srcB[4:0];
            intExecPkg::INT_SLT: result = {31'b0, lessThan};
            intExecPkg::INT_SLTU: result = {31'b0, lessThanU};
            // Upper immediate arrives already shifted on srcB
            intExecPkg::INT_LUI: result = srcB;
            intExecPkg::INT_AUIPC: result = uop.pc + imm;
            intExecPkg::INT_JAL,
            intExecPkg::INT_JALR: result = fallThrough;
            intExecPkg::INT_SH1ADD: result = srcB + (srcA << 1);
            intExecPkg::INT_SH2ADD: result = srcB + (srcA << 2);
            intExecPkg::INT_SH3ADD: result = srcB + (srcA << 3);
            intExecPkg::INT_ANDN: result = srcA & ~srcB;
            intExecPkg::INT_ORN: result = srcA | ~srcB;
            intExecPkg::INT_XNOR: result = srcA ^ ~srcB;
            intExecPkg::INT_SE_B: result = {{24{srcA[7]}}, srcA[7:0]};
            intExecPkg::INT_SE_H: result = {{16{srcA[15]}}, srcA[15:0]};
            intExecPkg::INT_ZE_H: result = {16'b0, srcA[15:0]};
            intExecPkg::INT_CLZ,
            intExecPkg::INT_CTZ: result = {26'b0, leadZeros};
            intExecPkg::INT_CPOP: result = {26'b0, popCount};
            intExecPkg::INT_MIN: result = lessThan ? srcA : srcB;
            intExecPkg::INT_MAX: result = lessThan ? srcB : srcA;
            intExecPkg::INT_MINU: result = lessThanU ? srcA : srcB;
            intExecPkg::INT_MAXU: result = lessThanU ? srcB : srcA;
            intExecPkg::INT_ORC_B: result = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                             {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            intExecPkg::INT_REV8: result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            default: result = '0;
        endcase
    end

    always_comb begin
        case (uop.opcode)
            intExecPkg::INT_UNDEFINED: flags = intExecPkg::FLAGS_EXCEPT;
            intExecPkg::INT_SYS: flags = imm[0] ? intExecPkg::FLAGS_BRK : intExecPkg::FLAGS_TRAP;
            default: flags = intExecPkg::FLAGS_NONE;
        endcase
    end

    always_comb begin
        case (uop.opcode)
            intExecPkg::INT_JAL,
            intExecPkg::INT_JALR: taken = 1'b1;
            intExecPkg::INT_BEQ: taken = srcA == srcB;
            intExecPkg::INT_BNE: taken = srcA != srcB;
            intExecPkg::INT_BLT: taken = lessThan;
            intExecPkg::INT_BGE: taken = !lessThan;
            intExecPkg::INT_BLTU: taken = lessThanU;
            intExecPkg::INT_BGEU: taken = !lessThanU;
            default: taken = 1'b0;
        endcase
    end

    // JALR is not predicted, so it stays out of the predictor update
    assign isBranch = uop.opcode inside {intExecPkg::INT_JAL, intExecPkg::INT_BEQ,
                                         intExecPkg::INT_BNE, intExecPkg::INT_BLT,
                                         intExecPkg::INT_BGE, intExecPkg::INT_BLTU,
                                         intExecPkg::INT_BGEU};

    always_comb begin
        resNext.valid = 1'b1;
        resNext.result = result;
        resNext.tagDst = uop.tagDst;
        resNext.nmDst = uop.nmDst;
        resNext.sqN = uop.sqN;
        resNext.flags = flags;
        resNext.pc = uop.pc;
        resNext.isBranch = isBranch;
        resNext.branchTaken = taken;
        resNext.branchId = uop.branchId;

        branchNext.isBranch = isBranch;
        branchNext.taken = taken;
        // Uncompressed branches are predicted at their second halfword
        branchNext.source = uop.compressed ? uop.pc : pcPlus2;
        branchNext.isJump = uop.opcode == intExecPkg::INT_JAL;
        branchNext.branchId = uop.branchId;
        branchNext.sqN = uop.sqN;
        branchNext.loadSqN = uop.loadSqN;
        branchNext.storeSqN = uop.storeSqN;
        branchNext.compressed = uop.compressed;
        if (uop.opcode == intExecPkg::INT_JALR) begin
            branchNext.mispred = 1'b1;
            branchNext.address = srcA + srcB;
        end else begin
            branchNext.mispred = isBranch && (taken != uop.branchPred);
            branchNext.address = taken ? branchTarget : fallThrough;
        end
    end

    assign killed = intExecPkg::isKilled(invalidate, uop.sqN, invalidateSqN);
    assign accept = uop.valid && !wbStall && !killed;

    always_ff @(posedge clk) begin
        if (rst) begin
            out.resUop.valid <= 1'b0;
            out.branch.isBranch <= 1'b0;
            out.branch.mispred <= 1'b0;
        end else if (accept) begin
            out.resUop <= resNext;
            out.branch <= branchNext;
        end else begin
            out.resUop.valid <= 1'b0;
            out.branch.isBranch <= 1'b0;
            out.branch.mispred <= 1'b0;
        end
    end

    // Zero-cycle forward to wakeup
    assign fwdValid = uop.valid && (uop.nmDst != '0);
    assign fwdTag = uop.tagDst;
    assign fwdResult = result;

endmodule

`default_nettype wire

// ==== source/writebackStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writebackStage (
    input wire clk,
    input wire rst,
    execUopIf.sink in,
    input wire invalidate,
    input wire intExecPkg::sqN_t invalidateSqN,
    output intExecPkg::resUop_s res,
    output intExecPkg::branchRes_s branch
);

    logic resKilled;
    logic branchKilled;

    assign resKilled = intExecPkg::isKilled(invalidate, in.resUop.sqN, invalidateSqN);
    assign branchKilled = intExecPkg::isKilled(invalidate, in.branch.sqN, invalidateSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
            branch.isBranch <= 1'b0;
            branch.mispred <= 1'b0;
        end else begin
            res <= in.resUop;
            res.valid <= in.resUop.valid && !resKilled;
            branch <= in.branch;
            // Late flush drops the record together with its redirect
            branch.isBranch <= in.branch.isBranch && !branchKilled;
            branch.mispred <= in.branch.mispred && !branchKilled;
        end
    end

endmodule

`default_nettype wire

// ==== source/intExecUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module intExecUnit (
    input wire clk,
    input wire rst,
    input wire uopValid,
    input wire intExecPkg::intOp_e opcode,
    input wire intExecPkg::word_t srcA,
    input wire intExecPkg::word_t srcB,
    input wire intExecPkg::word_t imm,
    input wire intExecPkg::word_t pc,
    input wire compressed,
    input wire branchPred,
    input wire intExecPkg::branchId_t branchId,
    input wire intExecPkg::sqN_t sqN,
    input wire intExecPkg::sqN_t loadSqN,
    input wire intExecPkg::sqN_t storeSqN,
    input wire intExecPkg::tag_t tagDst,
    input wire intExecPkg::regNm_t nmDst,
    input wire wbStall,
    input wire invalidate,
    input wire intExecPkg::sqN_t invalidateSqN,
    output wire fwdValid,
    output wire intExecPkg::tag_t fwdTag,
    output wire intExecPkg::word_t fwdResult,
    output wire resultValid,
    output wire intExecPkg::tag_t resultTag,
    output wire intExecPkg::regNm_t resultNmDst,
    output wire intExecPkg::word_t result,
    output wire intExecPkg::sqN_t resultSqN,
    output wire intExecPkg::flags_e resultFlags,
    output wire intExecPkg::word_t resultPc,
    output wire branchValid,
    output wire branchTaken,
    output wire branchMispred,
    output wire intExecPkg::word_t branchSource,
    output wire intExecPkg::word_t branchAddress,
    output wire branchIsJump,
    output wire intExecPkg::branchId_t branchIdOut,
    output wire intExecPkg::sqN_t branchSqN,
    output wire intExecPkg::sqN_t branchLoadSqN,
    output wire intExecPkg::sqN_t branchStoreSqN,
    output wire branchCompressed
);

    intExecPkg::exUop_s uopIn;
    intExecPkg::resUop_s wbRes;
    intExecPkg::branchRes_s wbBranch;

    execUopIf issueToAlu ();
    execUopIf aluToWb ();

    assign uopIn = '{
        valid: uopValid,
        opcode: opcode,
        srcA: srcA,
        srcB: srcB,
        imm: imm,
        pc: pc,
        compressed: compressed,
        branchPred: branchPred,
        branchId: branchId,
        sqN: sqN,
        loadSqN: loadSqN,
        storeSqN: storeSqN,
        tagDst: tagDst,
        nmDst: nmDst
    };

    issueStage issue_i (
        .clk(clk),
        .rst(rst),
        .uopIn(uopIn),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .out(issueToAlu.source)
    );

    intAlu alu_i (
        .clk(clk),
        .rst(rst),
        .in(issueToAlu.sink),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .out(aluToWb.source),
        .fwdValid(fwdValid),
        .fwdTag(fwdTag),
        .fwdResult(fwdResult)
    );

    writebackStage writeback_i (
        .clk(clk),
        .rst(rst),
        .in(aluToWb.sink),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .res(wbRes),
        .branch(wbBranch)
    );

    assign resultValid = wbRes.valid;
    assign resultTag = wbRes.tagDst;
    assign resultNmDst = wbRes.nmDst;
    assign result = wbRes.result;
    assign resultSqN = wbRes.sqN;
    assign resultFlags = wbRes.flags;
    assign resultPc = wbRes.pc;

    assign branchValid = wbBranch.isBranch;
    assign branchTaken = wbBranch.taken;
    assign branchMispred = wbBranch.mispred;
    assign branchSource = wbBranch.source;
    assign branchAddress = wbBranch.address;
    assign branchIsJump = wbBranch.isJump;
    assign branchIdOut = wbBranch.branchId;
    assign branchSqN = wbBranch.sqN;
    assign branchLoadSqN = wbBranch.loadSqN;
    assign branchStoreSqN = wbBranch.storeSqN;
    assign branchCompressed = wbBranch.compressed;

endmodule

`default_nettype wire

// ==== sim/intExecModel.svh ====
`ifndef INTEXEC_MODEL_SVH
`define INTEXEC_MODEL_SVH

`include "intExec_params.svh"

`default_nettype none

// Signed distance of wrapping sequence numbers
function automatic logic youngerThan(
    input intExecPkg::sqN_t sqN,
    input intExecPkg::sqN_t flushSqN
);
    logic signed [`SQN_W-1:0] diff;
    diff = sqN - flushSqN;
    return diff > 0;
endfunction

function automatic logic isConditional(input intExecPkg::intOp_e op);
    case (op)
        intExecPkg::INT_BEQ, intExecPkg::INT_BNE, intExecPkg::INT_BLT,
        intExecPkg::INT_BGE, intExecPkg::INT_BLTU, intExecPkg::INT_BGEU: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Zero for ops that produce no register value
function automatic intExecPkg::word_t expectedResult(
    input intExecPkg::intOp_e op,
    input intExecPkg::word_t a,
    input intExecPkg::word_t b,
    input intExecPkg::word_t imm,
    input intExecPkg::word_t pc,
    input logic compressed
);
    intExecPkg::word_t r;
    int n;
    r = '0;
    n = 0;
    case (op)
        intExecPkg::INT_ADD: r = a + b;
        intExecPkg::INT_SUB: r = a - b;
        intExecPkg::INT_XOR: r = a ^ b;
        intExecPkg::INT_OR: r = a | b;
        intExecPkg::INT_AND: r = a & b;
        intExecPkg::INT_SLL: r = a << b[4:0];
        intExecPkg::INT_SRL: r = a >> b[4:0];
        intExecPkg::INT_SRA: r = $signed(a) >>> b[4:0];
        intExecPkg::INT_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        intExecPkg::INT_SLTU: r = (a < b) ? 32'd1 : 32'd0;
        intExecPkg::INT_LUI: r = b;
        intExecPkg::INT_AUIPC: r = pc + imm;
        intExecPkg::INT_JAL,
        intExecPkg::INT_JALR: r = pc + (compressed ? 32'd2 : 32'd4);
        intExecPkg::INT_SH1ADD: r = a * 2 + b;
        intExecPkg::INT_SH2ADD: r = a * 4 + b;
        intExecPkg::INT_SH3ADD: r = a * 8 + b;
        intExecPkg::INT_ANDN: r = a & ~b;
        intExecPkg::INT_ORN: r = a | ~b;
        intExecPkg::INT_XNOR: r = ~(a ^ b);
        intExecPkg::INT_SE_B: r = 32'($signed(a[7:0]));
        intExecPkg::INT_SE_H: r = 32'($signed(a[15:0]));
        intExecPkg::INT_ZE_H: r = 32'(a[15:0]);
        intExecPkg::INT_CLZ: begin
            while (n < 32 && !a[31 - n]) begin
                n++;
            end
            r = n;
        end
        intExecPkg::INT_CTZ: begin
            while (n < 32 && !a[n]) begin
                n++;
            end
            r = n;
        end
        intExecPkg::INT_CPOP: begin
            for (int i = 0; i < 32; i++) begin
                n += a[i];
            end
            r = n;
        end
        intExecPkg::INT_MIN: r = ($signed(a) < $signed(b)) ? a : b;
        intExecPkg::INT_MAX: r = ($signed(a) > $signed(b)) ? a : b;
        intExecPkg::INT_MINU: r = (a < b) ? a : b;
        intExecPkg::INT_MAXU: r = (a > b) ? a : b;
        intExecPkg::INT_ORC_B: begin
            for (int i = 0; i < 4; i++) begin
                r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
            end
        end
        intExecPkg::INT_REV8: begin
            for (int i = 0; i < 4; i++) begin
                r[8*i +: 8] = a[8*(3-i) +: 8];
            end
        end
        default: r = '0;
    endcase
    return r;
endfunction

function automatic intExecPkg::flags_e expectedFlags(
    input intExecPkg::intOp_e op,
    input intExecPkg::word_t imm
);
    if (op == intExecPkg::INT_UNDEFINED) begin
        return intExecPkg::FLAGS_EXCEPT;
    end else if (op == intExecPkg::INT_SYS) begin
        return imm[0] ? intExecPkg::FLAGS_BRK : intExecPkg::FLAGS_TRAP;
    end else begin
        return intExecPkg::FLAGS_NONE;
    end
endfunction

function automatic logic expectedTaken(
    input intExecPkg::intOp_e op,
    input intExecPkg::word_t a,
    input intExecPkg::word_t b
);
    case (op)
        intExecPkg::INT_JAL, intExecPkg::INT_JALR: return 1'b1;
        intExecPkg::INT_BEQ: return a == b;
        intExecPkg::INT_BNE: return a != b;
        intExecPkg::INT_BLT: return $signed(a) < $signed(b);
        intExecPkg::INT_BGE: return $signed(a) >= $signed(b);
        intExecPkg::INT_BLTU: return a < b;
        intExecPkg::INT_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Redirect target or the fall-through address when not taken
function automatic intExecPkg::word_t expectedAddress(
    input intExecPkg::intOp_e op,
    input intExecPkg::word_t a,
    input intExecPkg::word_t b,
    input intExecPkg::word_t imm,
    input intExecPkg::word_t pc,
    input logic compressed,
    input logic taken
);
    intExecPkg::word_t offset;
    offset = 32'($signed(imm[12:0]));
    if (op == intExecPkg::INT_JALR) begin
        return a + b;
    end else if (taken) begin
        return pc + offset;
    end else begin
        return pc + (compressed ? 32'd2 : 32'd4);
    end
endfunction

`default_nettype wire

`endif

// ==== sim/intExecUnitTb.sv ====
`timescale 1ns/1ps

`include "intExec_params.svh"
`include "intExecModel.svh"

`default_nettype none

module intExecUnitTb;

    typedef struct packed {
        intExecPkg::sqN_t sqN;
        logic hasResult;
        intExecPkg::word_t result;
        intExecPkg::tag_t tagDst;
        intExecPkg::regNm_t nmDst;
        intExecPkg::flags_e flags;
        intExecPkg::word_t pc;
        logic isBranch;
        logic taken;
        logic mispred;
        intExecPkg::word_t source;
        intExecPkg::word_t address;
        logic isJump;
        intExecPkg::branchId_t branchId;
        intExecPkg::sqN_t loadSqN;
        intExecPkg::sqN_t storeSqN;
        logic compressed;
    } expEntry_s;

    logic clk;
    logic rst;
    logic uopValid;
    intExecPkg::intOp_e opcode;
    intExecPkg::word_t srcA;
    intExecPkg::word_t srcB;
    intExecPkg::word_t imm;
    intExecPkg::word_t pc;
    logic compressed;
    logic branchPred;
    intExecPkg::branchId_t branchId;
    intExecPkg::sqN_t sqN;
    intExecPkg::sqN_t loadSqN;
    intExecPkg::sqN_t storeSqN;
    intExecPkg::tag_t tagDst;
    intExecPkg::regNm_t nmDst;
    logic wbStall;
    logic invalidate;
    intExecPkg::sqN_t invalidateSqN;

    logic fwdValid;
    intExecPkg::tag_t fwdTag;
    intExecPkg::word_t fwdResult;
    logic resultValid;
    intExecPkg::tag_t resultTag;
    intExecPkg::regNm_t resultNmDst;
    intExecPkg::word_t result;
    intExecPkg::sqN_t resultSqN;
    intExecPkg::flags_e resultFlags;
    intExecPkg::word_t resultPc;
    logic branchValid;
    logic branchTaken;
    logic branchMispred;
    intExecPkg::word_t branchSource;
    intExecPkg::word_t branchAddress;
    logic branchIsJump;
    intExecPkg::branchId_t branchIdOut;
    intExecPkg::sqN_t branchSqN;
    intExecPkg::sqN_t branchLoadSqN;
    intExecPkg::sqN_t branchStoreSqN;
    logic branchCompressed;

    logic [15:0] lfsr;
    intExecPkg::sqN_t nextSqN;
    expEntry_s expQueue[$];
    int errors;

    intExecUnit intExecUnit_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Taps 16 14 13 11
    function automatic logic [`XLEN-1:0] lfsrBits(input int count);
        logic [`XLEN-1:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[`XLEN-2:0], fb};
        end
        return bits;
    endfunction

    task automatic compareField(
        input string name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic driveIdle();
        uopValid = 1'b0;
        opcode = intExecPkg::INT_ADD;
        srcA = '0;
        srcB = '0;
        imm = '0;
        pc = '0;
        compressed = 1'b0;
        branchPred = 1'b0;
        branchId = '0;
        sqN = nextSqN;
        loadSqN = '0;
        storeSqN = '0;
        tagDst = '0;
        nmDst = '0;
        wbStall = 1'b0;
        invalidate = 1'b0;
        invalidateSqN = '0;
    endtask

    task automatic driveRandom();
        int shift;
        wbStall = lfsrBits(2) == 0;
        uopValid = !wbStall && (lfsrBits(2) != 0);
        opcode = intExecPkg::intOp_e'(6'(lfsrBits(6) % 40));
        // Shifted operands give the counts a spread of leading zeros
        shift = lfsrBits(5);
        srcA = lfsrBits(32) >> shift;
        srcB = (lfsrBits(2) == 0) ? srcA : lfsrBits(32);
        imm = lfsrBits(32);
        pc = lfsrBits(31) << 1;
        compressed = lfsrBits(1);
        branchPred = lfsrBits(1);
        branchId = lfsrBits(6);
        if (uopValid) begin
            nextSqN = nextSqN + 6'(1 + lfsrBits(2));
        end
        sqN = nextSqN;
        loadSqN = lfsrBits(6);
        storeSqN = lfsrBits(6);
        tagDst = lfsrBits(6);
        nmDst = (lfsrBits(3) == 0) ? '0 : lfsrBits(5);
        invalidate = lfsrBits(4) == 0;
        invalidateSqN = nextSqN - 6'(lfsrBits(3));
    endtask

    function automatic expEntry_s buildExpected();
        expEntry_s e;
        e.sqN = sqN;
        e.hasResult = !isConditional(opcode) && opcode != intExecPkg::INT_SYS
            && opcode != intExecPkg::INT_UNDEFINED;
        e.result = expectedResult(opcode, srcA, srcB, imm, pc, compressed);
        e.tagDst = tagDst;
        e.nmDst = nmDst;
        e.flags = expectedFlags(opcode, imm);
        e.pc = pc;
        e.isBranch = isConditional(opcode) || opcode == intExecPkg::INT_JAL;
        e.taken = expectedTaken(opcode, srcA, srcB);
        e.mispred = opcode == intExecPkg::INT_JALR || (e.isBranch && e.taken != branchPred);
        e.source = compressed ? pc : pc + 32'd2;
        e.address = expectedAddress(opcode, srcA, srcB, imm, pc, compressed, e.taken);
        e.isJump = opcode == intExecPkg::INT_JAL;
        e.branchId = branchId;
        e.loadSqN = loadSqN;
        e.storeSqN = storeSqN;
        e.compressed = compressed;
        return e;
    endfunction

    task automatic pruneQueue(input intExecPkg::sqN_t flushSqN);
        expEntry_s kept[$];
        for (int i = 0; i < expQueue.size(); i++) begin
            if (!youngerThan(expQueue[i].sqN, flushSqN)) begin
                kept.push_back(expQueue[i]);
            end
        end
        expQueue = kept;
    endtask

    task automatic checkOutputs();
        expEntry_s e;
        if (!resultValid) begin
            if (branchValid || branchMispred) begin
                $display("Branch record at %0t without a result", $time);
                errors++;
            end
        end else if (expQueue.size() == 0) begin
            $display("Unexpected result at %0t for sqN %0d", $time, resultSqN);
            errors++;
        end else begin
            e = expQueue.pop_front();
            compareField("resultSqN", resultSqN, e.sqN);
            compareField("resultTag", resultTag, e.tagDst);
            compareField("resultNmDst", resultNmDst, e.nmDst);
            compareField("resultFlags", resultFlags, e.flags);
            compareField("resultPc", resultPc, e.pc);
            if (e.hasResult) begin
                compareField("result", result, e.result);
            end
            compareField("branchValid", branchValid, e.isBranch);
            compareField("branchMispred", branchMispred, e.mispred);
            if (e.isBranch) begin
                compareField("branchTaken", branchTaken, e.taken);
            end
            if (e.isBranch || e.mispred) begin
                compareField("branchAddress", branchAddress, e.address);
                compareField("branchSource", branchSource, e.source);
                compareField("branchIsJump", branchIsJump, e.isJump);
                compareField("branchIdOut", branchIdOut, e.branchId);
                compareField("branchSqN", branchSqN, e.sqN);
                compareField("branchLoadSqN", branchLoadSqN, e.loadSqN);
                compareField("branchStoreSqN", branchStoreSqN, e.storeSqN);
                compareField("branchCompressed", branchCompressed, e.compressed);
            end
        end
    endtask

    // One clock of model update and checks, then new inputs
    task automatic stepCycle(input logic newStimulus);
        expEntry_s e;
        logic accepted;
        logic killedIn;
        logic fwdExpected;
        @(posedge clk);
        #5;
        // Inputs still hold what the DUT sampled at this edge
        accepted = uopValid && !wbStall;
        killedIn = invalidate && youngerThan(sqN, invalidateSqN);
        e = buildExpected();
        if (accepted) begin
            expQueue.push_back(e);
        end
        if (invalidate) begin
            pruneQueue(invalidateSqN);
        end
        if (!wbStall) begin
            fwdExpected = accepted && !killedIn && (nmDst != '0);
            compareField("fwdValid", fwdValid, fwdExpected);
            if (fwdExpected) begin
                compareField("fwdTag", fwdTag, e.tagDst);
                if (e.hasResult) begin
                    compareField("fwdResult", fwdResult, e.result);
                end
            end
        end
        checkOutputs();
        if (newStimulus) begin
            driveRandom();
        end else begin
            driveIdle();
        end
    endtask

    initial begin
        int drainCycles;
        errors = 0;
        lfsr = 16'd81;
        nextSqN = '0;
        rst = 1'b1;
        driveIdle();
        // A live micro-op during reset must not leak out
        uopValid = 1'b1;
        nmDst = 5'd1;
        repeat (10) begin
            @(posedge clk);
            #5;
            compareField("resultValid", resultValid, 1'b0);
            compareField("branchValid", branchValid, 1'b0);
            compareField("branchMispred", branchMispred, 1'b0);
            compareField("fwdValid", fwdValid, 1'b0);
        end
        rst = 1'b0;
        driveIdle();
        repeat (2) begin
            stepCycle(1'b0);
        end
        repeat (2000) begin
            stepCycle(1'b1);
        end
        drainCycles = 0;
        while (expQueue.size() != 0 && drainCycles < 200) begin
            stepCycle(1'b0);
            drainCycles++;
        end
        if (expQueue.size() != 0) begin
            $display("Timeout after 200 cycles, %0d results never arrived", expQueue.size());
            errors++;
        end else begin
            repeat (3) begin
                stepCycle(1'b0);
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== intExec.f ====
+incdir+source
+incdir+sim
source/intExecPkg.sv
source/execUopIf.sv
source/bitCountUnit.sv
source/issueStage.sv
source/intAlu.sv
source/writebackStage.sv
source/intExecUnit.sv
sim/intExecUnitTb.sv
